// File: logic/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data path and instruction width
`define MIPS_WORD_W 32

// Architectural register count
`define MIPS_NUM_REGS 32

// Memory depths in words
`define MIPS_IMEM_DEPTH 64
`define MIPS_DMEM_DEPTH 64

`endif

// File: logic/mips_isa_pkg.sv
`include "mips_settings.svh"

package mips_isa_pkg;

    typedef logic [`MIPS_WORD_W-1:0] word_t;                   // Machine word
    typedef logic [$clog2(`MIPS_NUM_REGS)-1:0] reg_addr_t;     // Register number
    typedef logic [`MIPS_WORD_W-1:0] pc_t;                     // Byte address

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // Function field of R-type, bits 5:0
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

endpackage

// File: logic/mips_pipe_pkg.sv
package mips_pipe_pkg;

    import mips_isa_pkg::*;

    // Decoded control, travels with the instruction
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    branch;
        logic    alu_src;     // Immediate as operand B
        logic    reg_dst;     // rd as destination
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        pc_t   pc_plus4;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     reg_a;
        word_t     reg_b;
        word_t     imm;         // Sign extended
        reg_addr_t rt;
        reg_addr_t rd;
        pc_t       pc_plus4;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        logic      zero;
        word_t     alu_res;
        word_t     store_data;
        reg_addr_t dest;
        pc_t       branch_target;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_res;
        word_t     read_data;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

// File: logic/instruction_fetch.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module instruction_fetch import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic                                 i_clk,
    input  logic                                 i_arst_n,
    input  logic                                 i_stall,
    input  logic                                 i_load,
    input  logic                                 i_load_we,
    input  logic [$clog2(`MIPS_IMEM_DEPTH)-1:0]  i_load_addr,
    input  word_t                                i_load_data,
    input  logic                                 i_pc_src,
    input  pc_t                                  i_branch_target,
    output if_id_t                               o_if_id,
    output pc_t                                  o_pc
);

    localparam int IMEM_AW = $clog2(`MIPS_IMEM_DEPTH);

    word_t              imem [`MIPS_IMEM_DEPTH];
    pc_t                pc;
    pc_t                pc_plus4;
    pc_t                pc_next;
    logic [IMEM_AW-1:0] pc_idx;
    logic [IMEM_AW:0]   prog_end;       // Words loaded, one past last
    logic               load_q;
    logic               fetch_ok;
    word_t              instr;
    if_id_t             if_id_q;

    assign pc_idx   = pc[IMEM_AW+1:2];
    assign fetch_ok = (pc[`MIPS_WORD_W-1:IMEM_AW+2] == '0) && ({1'b0, pc_idx} < prog_end);
    assign instr    = fetch_ok ? imem[pc_idx] : '0;   // Outside the program reads a NOP
    assign pc_plus4 = pc + pc_t'(4);
    assign pc_next  = i_pc_src ? i_branch_target : pc_plus4;

    always_ff @(posedge i_clk) begin
        if (i_load && i_load_we) begin
            imem[i_load_addr] <= i_load_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc       <= '0;
            prog_end <= '0;
            load_q   <= 1'b0;
        end else begin
            load_q <= i_load;
            if (i_load) begin
                pc <= '0;                                       // Restart from address 0
                if (i_load_we) begin
                    prog_end <= {1'b0, i_load_addr} + 1'b1;
                end else if (!load_q) begin
                    prog_end <= '0;                             // New load session
                end
            end else if (!i_stall) begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            if_id_q <= '0;
        end else if (!(i_stall || i_load)) begin
            if_id_q.instr    <= instr;
            if_id_q.pc_plus4 <= pc_plus4;
        end
    end

    assign o_if_id = if_id_q;
    assign o_pc    = pc;

endmodule

// File: logic/instruction_decode.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module instruction_decode import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic    i_clk,
    input  logic    i_arst_n,
    input  logic    i_stall,
    input  logic    i_load,
    input  if_id_t  i_if_id,
    input  mem_wb_t i_mem_wb,
    output id_ex_t  o_id_ex
);

    word_t     regs [`MIPS_NUM_REGS];
    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     imm;
    ctrl_t     ctrl;
    word_t     wb_data;
    logic      wb_write;
    word_t     reg_a;
    word_t     reg_b;
    id_ex_t    id_ex_q;

    assign opcode = opcode_e'(i_if_id.instr[31:26]);
    assign funct  = funct_e'(i_if_id.instr[5:0]);
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign imm    = {{(`MIPS_WORD_W-16){i_if_id.instr[15]}}, i_if_id.instr[15:0]};

    // Main decoder, unknown encodings become NOPs
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;   // Covers the all-zero NOP
                endcase
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;   // Zero flag gives equality
            end
            default: ;
        endcase
    end

    // Write-back stage folded in here
    assign wb_data  = i_mem_wb.mem_to_reg ? i_mem_wb.read_data : i_mem_wb.alu_res;
    assign wb_write = i_mem_wb.reg_write && (i_mem_wb.dest != '0);

    always_ff @(posedge i_clk) begin
        if (wb_write && !(i_stall || i_load)) begin
            regs[i_mem_wb.dest] <= wb_data;
        end
    end

    // Register 0 reads zero, a write in flight is passed through
    always_comb begin
        if (rs == '0) begin
            reg_a = '0;
        end else if (wb_write && (i_mem_wb.dest == rs)) begin
            reg_a = wb_data;
        end else begin
            reg_a = regs[rs];
        end
        if (rt == '0) begin
            reg_b = '0;
        end else if (wb_write && (i_mem_wb.dest == rt)) begin
            reg_b = wb_data;
        end else begin
            reg_b = regs[rt];
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            id_ex_q <= '0;
        end else if (!(i_stall || i_load)) begin
            id_ex_q.ctrl     <= ctrl;
            id_ex_q.reg_a    <= reg_a;
            id_ex_q.reg_b    <= reg_b;
            id_ex_q.imm      <= imm;
            id_ex_q.rt       <= rt;
            id_ex_q.rd       <= rd;
            id_ex_q.pc_plus4 <= i_if_id.pc_plus4;
        end
    end

    assign o_id_ex = id_ex_q;

endmodule

// File: logic/execution.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module execution import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic    i_clk,
    input  logic    i_arst_n,
    input  logic    i_stall,
    input  logic    i_load,
    input  id_ex_t  i_id_ex,
    output ex_mem_t o_ex_mem
);

    word_t     op_b;
    word_t     alu_res;
    logic      zero;
    reg_addr_t dest;
    pc_t       branch_target;
    ex_mem_t   ex_mem_q;

    assign op_b = i_id_ex.ctrl.alu_src ? i_id_ex.imm : i_id_ex.reg_b;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: alu_res = i_id_ex.reg_a + op_b;
            ALU_SUB: alu_res = i_id_ex.reg_a - op_b;
            ALU_AND: alu_res = i_id_ex.reg_a & op_b;
            ALU_OR:  alu_res = i_id_ex.reg_a | op_b;
            ALU_SLT: alu_res = word_t'($signed(i_id_ex.reg_a) < $signed(op_b));  // Signed compare
            default: alu_res = '0;
        endcase
    end

    assign zero          = (alu_res == '0);
    assign dest          = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;
    assign branch_target = i_id_ex.pc_plus4 + {i_id_ex.imm[`MIPS_WORD_W-3:0], 2'b00};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ex_mem_q <= '0;
        end else if (!(i_stall || i_load)) begin
            ex_mem_q.ctrl          <= i_id_ex.ctrl;
            ex_mem_q.zero          <= zero;
            ex_mem_q.alu_res       <= alu_res;
            ex_mem_q.store_data    <= i_id_ex.reg_b;   // Unselected rt value for sw
            ex_mem_q.dest          <= dest;
            ex_mem_q.branch_target <= branch_target;
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

// File: logic/data_memory.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module data_memory import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_stall,
    input  logic                                i_load,
    input  ex_mem_t                             i_ex_mem,
    input  logic [$clog2(`MIPS_DMEM_DEPTH)-1:0] i_dbg_addr,
    output mem_wb_t                             o_mem_wb,
    output logic                                o_pc_src,
    output pc_t                                 o_branch_target,
    output word_t                               o_dbg_data
);

    localparam int DMEM_AW = $clog2(`MIPS_DMEM_DEPTH);

    word_t              ram [`MIPS_DMEM_DEPTH];
    logic [DMEM_AW-1:0] word_idx;
    word_t              read_data;
    mem_wb_t            mem_wb_q;

    assign word_idx  = i_ex_mem.alu_res[DMEM_AW+1:2];   // Word addressed
    assign read_data = i_ex_mem.ctrl.mem_read ? ram[word_idx] : '0;

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.ctrl.mem_write && !(i_stall || i_load)) begin
            ram[word_idx] <= i_ex_mem.store_data;
        end
    end

    // Branch resolves here
    assign o_pc_src        = i_ex_mem.ctrl.branch & i_ex_mem.zero;
    assign o_branch_target = i_ex_mem.branch_target;

    assign o_dbg_data = ram[i_dbg_addr];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_wb_q <= '0;
        end else if (!(i_stall || i_load)) begin
            mem_wb_q.reg_write  <= i_ex_mem.ctrl.reg_write;
            mem_wb_q.mem_to_reg <= i_ex_mem.ctrl.mem_to_reg;
            mem_wb_q.alu_res    <= i_ex_mem.alu_res;
            mem_wb_q.read_data  <= read_data;
            mem_wb_q.dest       <= i_ex_mem.dest;
        end
    end

    assign o_mem_wb = mem_wb_q;

endmodule

// File: logic/mips.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module mips import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_stall,
    input  logic                                i_load,
    input  logic                                i_load_we,
    input  logic [$clog2(`MIPS_IMEM_DEPTH)-1:0] i_load_addr,
    input  word_t                               i_load_data,
    input  logic [$clog2(`MIPS_DMEM_DEPTH)-1:0] i_dbg_addr,
    output word_t                               o_dbg_data,
    output pc_t                                 o_pc
);

    if_id_t  if_to_id;
    id_ex_t  id_to_ex;
    ex_mem_t ex_to_mem;
    mem_wb_t mem_to_wb;      // Also the write-back path
    logic    pc_src;
    pc_t     branch_target;

    instruction_fetch u_if (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_stall         (i_stall),
        .i_load          (i_load),
        .i_load_we       (i_load_we),
        .i_load_addr     (i_load_addr),
        .i_load_data     (i_load_data),
        .i_pc_src        (pc_src),
        .i_branch_target (branch_target),
        .o_if_id         (if_to_id),
        .o_pc            (o_pc)
    );

    instruction_decode u_id (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_stall  (i_stall),
        .i_load   (i_load),
        .i_if_id  (if_to_id),
        .i_mem_wb (mem_to_wb),
        .o_id_ex  (id_to_ex)
    );

    execution u_ex (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_stall  (i_stall),
        .i_load   (i_load),
        .i_id_ex  (id_to_ex),
        .o_ex_mem (ex_to_mem)
    );

    data_memory u_mem (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_stall         (i_stall),
        .i_load          (i_load),
        .i_ex_mem        (ex_to_mem),
        .i_dbg_addr      (i_dbg_addr),
        .o_mem_wb        (mem_to_wb),
        .o_pc_src        (pc_src),
        .o_branch_target (branch_target),
        .o_dbg_data      (o_dbg_data)
    );

endmodule

// File: tb/mips_tb_programs.svh
`ifndef MIPS_TB_PROGRAMS_SVH
`define MIPS_TB_PROGRAMS_SVH

localparam int ALU_ROUNDS = 3;
localparam int ALU_LEN    = ALU_ROUNDS * 16;
localparam int MEM_LEN    = 22;
localparam int BR_LEN     = 17;

function automatic word_t r_type_word(funct_e fn, int rs, int rt, int rd);
    return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

function automatic word_t i_type_word(opcode_e op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic void emit_word(word_t w);
    prog[prog_len] = w;
    prog_len       = prog_len + 1;
endfunction

function automatic void emit_nops(int n);
    for (int i = 0; i < n; i++) begin
        emit_word('0);
    end
endfunction

// Random operands, every R-type result stored at words 8*round + 0..4
function automatic void alu_program();
    int a;
    int b;
    prog_len = 0;
    for (int r = 0; r < ALU_ROUNDS; r++) begin
        a = $urandom();
        b = $urandom();
        emit_word(i_type_word(OP_ADDI, 0, 1, a));
        emit_word(i_type_word(OP_ADDI, 0, 2, b));
        emit_nops(2);
        emit_word(r_type_word(FN_ADD, 1, 2, 3));
        emit_word(r_type_word(FN_SUB, 1, 2, 4));
        emit_word(r_type_word(FN_AND, 1, 2, 5));
        emit_word(r_type_word(FN_OR, 1, 2, 6));
        emit_word(r_type_word(FN_SLT, 1, 2, 7));
        emit_nops(2);
        for (int k = 0; k < 5; k++) begin
            emit_word(i_type_word(OP_SW, 0, 3 + k, r * 32 + k * 4));
        end
    end
endfunction

// Base register points at word 56, offsets reach back to word 48
function automatic void mem_program();
    prog_len = 0;
    emit_word(i_type_word(OP_ADDI, 0, 1, $urandom()));
    emit_word(i_type_word(OP_ADDI, 0, 2, $urandom()));
    emit_word(i_type_word(OP_ADDI, 0, 5, 224));
    emit_nops(2);
    emit_word(i_type_word(OP_SW, 5, 1, -32));
    emit_word(i_type_word(OP_SW, 5, 2, -28));
    emit_word(i_type_word(OP_LW, 5, 3, -32));
    emit_word(i_type_word(OP_LW, 5, 4, -28));
    emit_nops(2);
    emit_word(r_type_word(FN_ADD, 3, 4, 6));
    emit_word(r_type_word(FN_SUB, 3, 4, 7));
    emit_nops(2);
    emit_word(i_type_word(OP_SW, 5, 6, 4));
    emit_word(i_type_word(OP_SW, 5, 7, -24));
    emit_word(i_type_word(OP_LW, 5, 8, 4));     // Copy back the sum
    emit_nops(3);
    emit_word(i_type_word(OP_SW, 5, 8, -20));
endfunction

// Markers at words 40 to 42
function automatic void branch_program();
    prog_len = 0;
    emit_word(i_type_word(OP_ADDI, 0, 1, 5));
    emit_word(i_type_word(OP_ADDI, 0, 2, 5));
    emit_word(i_type_word(OP_ADDI, 0, 3, 7));
    emit_word(i_type_word(OP_ADDI, 0, 4, $urandom_range(32767, 1)));
    emit_word(i_type_word(OP_SW, 0, 0, 160));
    emit_word(i_type_word(OP_SW, 0, 0, 164));
    emit_word(i_type_word(OP_BEQ, 1, 2, 4));    // Taken
    emit_nops(3);
    emit_word(i_type_word(OP_SW, 0, 4, 160));   // Skipped
    emit_word(i_type_word(OP_BEQ, 1, 3, 4));    // Not taken
    emit_nops(3);
    emit_word(i_type_word(OP_SW, 0, 4, 164));
    emit_word(i_type_word(OP_SW, 0, 4, 168));
endfunction

// Sequential ISA model, updates the expected memory image
function automatic void ref_run();
    word_t regs [`MIPS_NUM_REGS];
    word_t ins;
    word_t a;
    word_t b;
    word_t imm;
    word_t addr;
    int    pc;
    int    steps;
    foreach (regs[i]) regs[i] = '0;
    pc    = 0;
    steps = 0;
    while (pc < prog_len && steps < 4 * prog_len) begin
        ins   = prog[pc];
        a     = regs[ins[25:21]];
        b     = regs[ins[20:16]];
        imm   = {{16{ins[15]}}, ins[15:0]};
        addr  = a + imm;
        pc    = pc + 1;
        steps = steps + 1;
        case (ins[31:26])
            OP_RTYPE: begin
                case (ins[5:0])
                    FN_ADD:  regs[ins[15:11]] = a + b;
                    FN_SUB:  regs[ins[15:11]] = a - b;
                    FN_AND:  regs[ins[15:11]] = a & b;
                    FN_OR:   regs[ins[15:11]] = a | b;
                    FN_SLT:  regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: ;
                endcase
            end
            OP_ADDI: regs[ins[20:16]] = a + imm;
            OP_LW:   regs[ins[20:16]] = model_mem[addr[7:2]];
            OP_SW: begin
                model_mem[addr[7:2]]   = b;
                model_known[addr[7:2]] = 1'b1;
            end
            OP_BEQ: if (a == b) pc = pc + $signed(imm);   // Delay slots hold NOPs
            default: ;
        endcase
        regs[0] = '0;
    end
endfunction

`endif

// File: tb/mips_tb.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module mips_tb import mips_isa_pkg::*; ();

    localparam int IMEM_AW = $clog2(`MIPS_IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(`MIPS_DMEM_DEPTH);

    logic               clk;
    logic               arst_n;
    logic               stall;
    logic               load;
    logic               load_we;
    logic [IMEM_AW-1:0] load_addr;
    word_t              load_data;
    logic [DMEM_AW-1:0] dbg_addr;
    word_t              dbg_data;
    pc_t                pc;

    word_t prog [`MIPS_IMEM_DEPTH];
    int    prog_len;
    word_t model_mem [`MIPS_DMEM_DEPTH];     // Expected data memory image
    logic  model_known [`MIPS_DMEM_DEPTH];   // Words stored by some test
    int    test_errors;
    int    pass_count;
    int    fail_count;
    event  check_req;
    event  check_done;

    `include "mips_tb_programs.svh"

    // Four cycles per word plus 8 for each test, stall test at most doubled
    localparam int BUDGET_CYCLES   = 4 * (3 * ALU_LEN + MEM_LEN + BR_LEN + 5 * 8);
    localparam int LOAD_CYCLES     = 2 * ALU_LEN + MEM_LEN + BR_LEN + 20;
    localparam int WATCHDOG_CYCLES = BUDGET_CYCLES + LOAD_CYCLES + 200;

    mips DUT (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_stall     (stall),
        .i_load      (load),
        .i_load_we   (load_we),
        .i_load_addr (load_addr),
        .i_load_data (load_data),
        .i_dbg_addr  (dbg_addr),
        .o_dbg_data  (dbg_data),
        .o_pc        (pc)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_pc_zero();
        assert (pc === '0) else begin
            $display("mismatch at %0t: o_pc expected %h actual %h", $time, pc_t'(0), pc);
            test_errors++;
        end
    endtask

    task automatic load_program();
        load = 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            load_we   = 1'b1;
            load_addr = IMEM_AW'(i);
            load_data = prog[i];
            @(posedge clk);
            #10;
        end
        load_we = 1'b0;
        load    = 1'b0;   // Release with PC at 0
    endtask

    // Stalled cycles do not count towards the budget
    task automatic run_program(input int budget, input bit with_stall);
        int done;
        int stalls;
        done   = 0;
        stalls = 0;
        while (done < budget) begin
            stall = with_stall && (stalls < budget) && ($urandom_range(3) == 0);
            if (stall) begin
                stalls++;
            end else begin
                done++;
            end
            @(posedge clk);
            #10;
        end
        stall = 1'b0;
        load  = 1'b1;     // Freeze for readback
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %-16s %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic run_test(input string name, input bit with_stall);
        ref_run();
        load_program();
        run_program(4 * (prog_len + 8), with_stall);
        -> check_req;
        @(check_done);
        @(posedge clk);
        #10;
        report_test(name);
    endtask

    // Reads back every data word and compares the known ones
    initial begin : compare_memory
        dbg_addr = '0;
        forever begin
            @(check_req);
            for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
                dbg_addr = DMEM_AW'(i);
                #1;
                if (model_known[i]) begin
                    assert (dbg_data === model_mem[i]) else begin
                        $display("mismatch at %0t: o_dbg_data[%0d] expected %h actual %h",
                                 $time, i, model_mem[i], dbg_data);
                        test_errors++;
                    end
                end
            end
            -> check_done;
        end
    end

    initial begin : main_sequence
        void'($urandom(32'h20b1));
        arst_n      = 1'b0;
        stall       = 1'b0;
        load        = 1'b1;   // Hold the PC until the first program
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        prog_len    = 0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        foreach (model_known[i]) model_known[i] = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        check_pc_zero();
        arst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #10;
            check_pc_zero();
        end
        report_test("pc hold");
        alu_program();
        run_test("alu ops", 1'b0);
        mem_program();
        run_test("load store", 1'b0);
        branch_program();
        run_test("beq", 1'b0);
        alu_program();
        run_test("alu with stall", 1'b1);
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 100);
        $display("timeout after %0d cycles, test sequence did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: mips_core.f
+incdir+logic
+incdir+tb
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/instruction_fetch.sv
logic/instruction_decode.sv
logic/execution.sv
logic/data_memory.sv
logic/mips.sv
tb/mips_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the MIPS core testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal --top-module mips_tb -f mips_core.f \
    > build.log 2>&1 \
    || { cat build.log; echo "Verilator build error"; exit 1; }
./obj_dir/Vmips_tb > sim.log 2>&1 ; cat sim.log
! grep -q "Simulation failed" sim.log \
    && grep -q "Simulation completed successfully" sim.log \
    && exit 0 \
    || exit 1
